// File: Makefile
# Verilator build and run for the UDP echo testbench

VERILATOR ?= verilator
TOP       := tb_udp_echo
FLIST     := udp_echo.f
VFLAGS    := --binary --timing -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/echo_ctrl.sv
// Per-frame echo control
// Accepts or discards rx headers by destination port
// Gates the rx payload stream into the FIFO or drops it

`timescale 1ns/10ps
`default_nettype none

module echo_ctrl #(
    parameter logic [15:0] ECHO_PORT = 16'd1234
) (
    input  wire        clk,
    input  wire        rst,

    // rx header
    input  wire        rx_hdr_valid,
    output logic       rx_hdr_ready,
    input  wire [15:0] rx_hdr_dest_port,

    // Reply header builder
    input  wire        hdr_full,
    output logic       hdr_load,

    // rx payload
    input  wire        rx_payload_valid,
    input  wire        rx_payload_last,
    output logic       rx_payload_ready,

    // FIFO input
    output logic       fifo_in_valid,
    input  wire        fifo_in_ready
);

    import udp_echo_pkg::*;

    echo_state_t state;
    echo_state_t state_next;

    logic port_match;
    logic hdr_xfer;
    logic last_xfer;

    assign port_match = (rx_hdr_dest_port == ECHO_PORT);

    // A matching header must wait for a free reply slot
    assign rx_hdr_ready = (state == IDLE) && rx_hdr_valid && (!port_match || !hdr_full);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_xfer && port_match;

    // Payload goes to the FIFO in FORWARD and is swallowed in DISCARD
    assign fifo_in_valid    = (state == FORWARD) && rx_payload_valid;
    assign rx_payload_ready = (state == FORWARD) ? fifo_in_ready : (state == DISCARD);
    assign last_xfer        = rx_payload_valid && rx_payload_ready && rx_payload_last;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_xfer) begin
                    state_next = port_match ? FORWARD : DISCARD;
                end
            end
            FORWARD, DISCARD: begin
                if (last_xfer) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/led_capture.sv
// LED capture of the first byte of each echoed frame
// Watches the tx payload transfers

`timescale 1ns/10ps
`default_nettype none

module led_capture (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               beat_valid,
    input  wire                               beat_ready,
    input  wire udp_echo_pkg::udp_byte_t      beat,
    output logic [udp_echo_pkg::BYTE_W-1:0]   led
);

    logic frame_started;
    logic xfer;

    assign xfer = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_started <= 1'b0;
            led           <= '0;
        end else if (xfer) begin
            if (!frame_started) begin
                led <= beat.data;
            end
            // A single-byte frame starts and ends on the same beat
            frame_started <= !beat.last;
        end
    end

endmodule

`default_nettype wire

// File: logic/payload_fifo.sv
// Synchronous byte FIFO for the echoed payload
// Circular buffer of whole beats (data, last, user)
// Read and write pointers with an occupancy count

`timescale 1ns/10ps
`default_nettype none

module payload_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire                     clk,
    input  wire                     rst,

    // Input side
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire udp_echo_pkg::udp_byte_t in_beat,

    // Output side
    output logic                    out_valid,
    input  wire                     out_ready,
    output udp_echo_pkg::udp_byte_t out_beat
);

    import udp_echo_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

    udp_byte_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != FULL_COUNT);
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // Simultaneous write and read keeps the level
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/reply_header_build.sv
// Reply header builder
// One-entry register that turns a received UDP header into its echo reply
// and holds it until the tx header transfer

`timescale 1ns/10ps
`default_nettype none

module reply_header_build #(
    parameter logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  wire                    clk,
    input  wire                    rst,

    input  wire                    hdr_load,
    input  wire udp_echo_pkg::udp_hdr_t rx_hdr,
    output logic                   hdr_full,

    // tx header
    output logic                   tx_hdr_valid,
    input  wire                    tx_hdr_ready,
    output udp_echo_pkg::udp_hdr_t tx_hdr
);

    import udp_echo_pkg::*;

    // Reply fields captured on the load strobe
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_hdr.ip_dscp     <= '0;
            tx_hdr.ip_ecn      <= '0;
            tx_hdr.ip_ttl      <= REPLY_TTL;
            tx_hdr.source_ip   <= LOCAL_IP;
            tx_hdr.dest_ip     <= rx_hdr.source_ip;
            // Ports swap so the reply goes back to the sender's socket
            tx_hdr.source_port <= rx_hdr.dest_port;
            tx_hdr.dest_port   <= rx_hdr.source_port;
            tx_hdr.length      <= rx_hdr.length;
            tx_hdr.checksum    <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Slot is busy until the reply has gone out
    assign hdr_full = tx_hdr_valid;

endmodule

`default_nettype wire

// File: logic/udp_echo_pkg.sv
// Shared types and constants for the UDP echo application
// UDP header with IP fields, payload beat, control state enum
// Reply TTL and payload data width

`default_nettype none

package udp_echo_pkg;

    // Payload data width in bits
    localparam int BYTE_W = 8;

    // TTL written into every echo reply
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Parsed UDP header of 144 bits with the IP fields the stack needs
    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload byte with frame end and error flag
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              last;
        logic              user;
    } udp_byte_t;

    // Per-frame control states
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DISCARD
    } echo_state_t;

endpackage

`default_nettype wire

// File: logic/udp_echo_top.sv
// UDP echo application top level
// Connects the echo control, reply header builder, payload FIFO
// and LED capture

`timescale 1ns/10ps
`default_nettype none

module udp_echo_top #(
    parameter logic [15:0] ECHO_PORT  = 16'd1234,
    parameter logic [31:0] LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter int          FIFO_DEPTH = 64
) (
    input  wire                             clk,
    input  wire                             rst,

    // rx header
    input  wire                             rx_hdr_valid,
    output logic                            rx_hdr_ready,
    input  wire udp_echo_pkg::udp_hdr_t     rx_hdr,

    // rx payload
    input  wire                             rx_payload_valid,
    output logic                            rx_payload_ready,
    input  wire udp_echo_pkg::udp_byte_t    rx_payload,

    // tx header
    output logic                            tx_hdr_valid,
    input  wire                             tx_hdr_ready,
    output udp_echo_pkg::udp_hdr_t          tx_hdr,

    // tx payload
    output logic                            tx_payload_valid,
    input  wire                             tx_payload_ready,
    output udp_echo_pkg::udp_byte_t         tx_payload,

    output logic [udp_echo_pkg::BYTE_W-1:0] led
);

    logic hdr_load;
    logic hdr_full;
    logic fifo_in_valid;
    logic fifo_in_ready;

    echo_ctrl #(
        .ECHO_PORT(ECHO_PORT)
    ) u_echo_ctrl (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_hdr_dest_port (rx_hdr.dest_port),
        .hdr_full         (hdr_full),
        .hdr_load         (hdr_load),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_last  (rx_payload.last),
        .rx_payload_ready (rx_payload_ready),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready)
    );

    reply_header_build #(
        .LOCAL_IP(LOCAL_IP)
    ) u_reply_header_build (
        .clk          (clk),
        .rst          (rst),
        .hdr_load     (hdr_load),
        .rx_hdr       (rx_hdr),
        .hdr_full     (hdr_full),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_hdr       (tx_hdr)
    );

    // Payload data enters the FIFO as received and only valid is gated
    payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .in_beat   (rx_payload),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready),
        .out_beat  (tx_payload)
    );

    led_capture u_led_capture (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .beat       (tx_payload),
        .led        (led)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// Testbench clock and reset generator
// Free-running clock and an active-high reset held for a number of cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge away from the DUT's sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/tb_udp_echo.sv
// Directed testbench for the UDP echo top level
// Reference model of the echo rule with expected header, byte and LED queues
// Reset, echo, discard and back-pressure tests with a cycle timeout

`timescale 1ns/10ps
`default_nettype none

module tb_udp_echo;

    import udp_echo_pkg::*;

    localparam logic [15:0] ECHO_PORT  = 16'd1234;
    localparam logic [31:0] LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam int          FIFO_DEPTH = 64;
    localparam int          MAX_LEN    = 32;
    localparam int          SEED       = 32'h3891_5bce;

    // Cycle budget for 6 echo, 7 discard test and 5 back-pressure frames
    // One back-pressure frame is longer than the FIFO
    localparam int FRAMES         = 18;
    localparam int BYTES          = (FRAMES - 1) * MAX_LEN + FIFO_DEPTH + 16;
    localparam int RUN_CYCLES     = 10 + 4 * BYTES + 20 * FRAMES + 4 * FIFO_DEPTH;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    localparam int READY_ON   = 0;
    localparam int READY_RAND = 1;
    localparam int READY_OFF  = 2;

    logic       clk;
    logic       rst;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    udp_hdr_t   rx_hdr;
    logic       rx_payload_valid;
    logic       rx_payload_ready;
    udp_byte_t  rx_payload;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    udp_hdr_t   tx_hdr;
    logic       tx_payload_valid;
    logic       tx_payload_ready;
    udp_byte_t  tx_payload;
    logic [7:0] led;

    udp_hdr_t   exp_hdr[$];
    udp_byte_t  exp_bytes[$];
    logic [7:0] exp_led[$];
    udp_hdr_t   hdr_want;
    udp_byte_t  beat_want;
    logic [7:0] led_want;
    logic       led_check_due = 1'b0;
    logic [7:0] last_echo_led = 8'h00;

    int hdr_ready_mode;
    int pay_ready_mode;
    int check_errors    = 0;
    int stream_errors   = 0;
    int hdrs_checked    = 0;
    int bytes_checked   = 0;
    int rx_stall_cycles = 0;
    int cycle_count;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) u_clock_gen (.clk(clk), .rst(rst));

    udp_echo_top #(
        .ECHO_PORT  (ECHO_PORT),
        .LOCAL_IP   (LOCAL_IP),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_udp_echo_top (
        .clk (clk), .rst (rst),
        .rx_hdr_valid (rx_hdr_valid), .rx_hdr_ready (rx_hdr_ready), .rx_hdr (rx_hdr),
        .rx_payload_valid (rx_payload_valid), .rx_payload_ready (rx_payload_ready),
        .rx_payload (rx_payload),
        .tx_hdr_valid (tx_hdr_valid), .tx_hdr_ready (tx_hdr_ready), .tx_hdr (tx_hdr),
        .tx_payload_valid (tx_payload_valid), .tx_payload_ready (tx_payload_ready),
        .tx_payload (tx_payload),
        .led (led)
    );

    task automatic print_mismatch(input string name, input string exp_s, input string got_s);
        $display("ERR %0t %s expected %s got %s", $time, name, exp_s, got_s);
    endtask

    task automatic print_summary();
        $display("Summary: %0d check errors, %0d stream errors, %0d headers and %0d bytes checked",
                 check_errors, stream_errors, hdrs_checked, bytes_checked);
    endtask

    task automatic check_low(input string name, input logic got);
        if (got !== 1'b0) begin
            print_mismatch(name, "0", $sformatf("%b", got));
            check_errors++;
        end
    endtask

    function automatic logic pick_ready(input int mode);
        case (mode)
            READY_ON:   return 1'b1;
            READY_RAND: return 1'($urandom);
            default:    return 1'b0;
        endcase
    endfunction

    function automatic udp_hdr_t random_header(input logic [15:0] port, input int len);
        udp_hdr_t h;
        h.ip_dscp     = 6'($urandom);
        h.ip_ecn      = 2'($urandom);
        h.ip_ttl      = 8'($urandom);
        h.source_ip   = $urandom;
        h.dest_ip     = LOCAL_IP;
        h.source_port = 16'($urandom);
        h.dest_port   = port;
        h.length      = 16'(len + 8);
        h.checksum    = 16'($urandom);
        return h;
    endfunction

    // Echo rule with swapped ports, answered from the local IP to the sender
    function automatic udp_hdr_t expected_reply(input udp_hdr_t rx);
        udp_hdr_t r;
        r             = '0;
        r.ip_ttl      = 8'd64;
        r.source_ip   = LOCAL_IP;
        r.dest_ip     = rx.source_ip;
        r.source_port = rx.dest_port;
        r.dest_port   = rx.source_port;
        r.length      = rx.length;
        return r;
    endfunction

    task automatic send_frame(input logic [15:0] port, input int len, input bit gaps);
        udp_hdr_t  hdr;
        udp_byte_t beat;
        bit        echo;
        int        i;
        echo = (port == ECHO_PORT);
        hdr  = random_header(port, len);
        if (echo) begin
            exp_hdr.push_back(expected_reply(hdr));
        end
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        @(posedge clk);
        while (!rx_hdr_ready) @(posedge clk);
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (i = 0; i < len; i++) begin
            beat.data = 8'($urandom);
            beat.last = (i == len - 1);
            beat.user = ($urandom_range(0, 7) == 0);
            if (echo) begin
                exp_bytes.push_back(beat);
                if (i == 0) begin
                    exp_led.push_back(beat.data);
                    last_echo_led = beat.data;
                end
            end
            if (gaps && $urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) @(negedge clk);
            end
            rx_payload       = beat;
            rx_payload_valid = 1'b1;
            @(posedge clk);
            while (!rx_payload_ready) @(posedge clk);
            @(negedge clk);
            rx_payload_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_hdr.size() != 0 || exp_bytes.size() != 0) begin
            @(negedge clk);
        end
        // Room for the LED update after the last byte
        repeat (2) @(negedge clk);
    endtask

    task automatic check_idle(input string when);
        check_low({when, " tx_hdr_valid"}, tx_hdr_valid);
        check_low({when, " tx_payload_valid"}, tx_payload_valid);
        check_low({when, " rx_hdr_ready"}, rx_hdr_ready);
        check_low({when, " rx_payload_ready"}, rx_payload_ready);
        if (led !== 8'h00) begin
            print_mismatch({when, " led"}, "00", $sformatf("%h", led));
            check_errors++;
        end
    endtask

    task automatic test_reset();
        @(posedge clk);
        while (rst) begin
            @(negedge clk);
            check_idle("reset");
        end
        @(negedge clk);
        check_idle("after reset");
    endtask

    task automatic test_echo();
        send_frame(ECHO_PORT, 1, 1'b0);
        send_frame(ECHO_PORT, 2, 1'b0);
        send_frame(ECHO_PORT, MAX_LEN, 1'b0);
        repeat (3) send_frame(ECHO_PORT, $urandom_range(1, MAX_LEN), 1'b1);
        wait_drain();
    endtask

    task automatic test_discard();
        send_frame(ECHO_PORT, $urandom_range(1, MAX_LEN), 1'b0);
        wait_drain();
        send_frame(ECHO_PORT - 16'd1, $urandom_range(1, MAX_LEN), 1'b1);
        send_frame(ECHO_PORT + 16'd1, $urandom_range(1, MAX_LEN), 1'b0);
        send_frame(16'd53, $urandom_range(1, MAX_LEN), 1'b1);
        repeat (8) @(negedge clk);
        check_low("discard tx_hdr_valid", tx_hdr_valid);
        check_low("discard tx_payload_valid", tx_payload_valid);
        if (led !== last_echo_led) begin
            print_mismatch("led", $sformatf("%h", last_echo_led), $sformatf("%h", led));
            check_errors++;
        end
        send_frame(ECHO_PORT, $urandom_range(1, MAX_LEN), 1'b0);
        send_frame(16'd7, $urandom_range(1, MAX_LEN), 1'b0);
        send_frame(ECHO_PORT, $urandom_range(1, MAX_LEN), 1'b1);
        wait_drain();
    endtask

    task automatic test_backpressure();
        int stalls_before;
        int waited;
        stalls_before  = rx_stall_cycles;
        hdr_ready_mode = READY_OFF;
        pay_ready_mode = READY_OFF;
        fork
            send_frame(ECHO_PORT, FIFO_DEPTH + 16, 1'b0);
            begin
                waited = 0;
                while (rx_stall_cycles == stalls_before && waited < 4 * FIFO_DEPTH) begin
                    @(negedge clk);
                    waited++;
                end
                repeat (16) @(negedge clk);
                hdr_ready_mode = READY_RAND;
                pay_ready_mode = READY_RAND;
            end
        join
        if (rx_stall_cycles == stalls_before) begin
            $display("rx_payload_ready never dropped while the tx payload was held off");
            check_errors++;
        end
        repeat (4) send_frame(ECHO_PORT, $urandom_range(1, MAX_LEN), 1'b1);
        wait_drain();
        hdr_ready_mode = READY_ON;
        pay_ready_mode = READY_ON;
    endtask

    // tx ready patterns applied on the falling edge
    initial begin
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        forever begin
            @(negedge clk);
            tx_hdr_ready     = pick_ready(hdr_ready_mode);
            tx_payload_ready = pick_ready(pay_ready_mode);
        end
    end

    // Output monitor that compares every tx transfer against the model queues
    always @(posedge clk) begin
        if (!rst) begin
            if (led_check_due) begin
                if (led !== led_want) begin
                    print_mismatch("led", $sformatf("%h", led_want), $sformatf("%h", led));
                    stream_errors++;
                end
                led_check_due = 1'b0;
            end
            if (rx_payload_valid && !rx_payload_ready) begin
                rx_stall_cycles++;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    $display("Unexpected tx header at %0t with no echoed frame pending", $time);
                    stream_errors++;
                end else begin
                    hdr_want = exp_hdr.pop_front();
                    if (tx_hdr !== hdr_want) begin
                        print_mismatch("tx_hdr", $sformatf("%h", hdr_want),
                                       $sformatf("%h", tx_hdr));
                        stream_errors++;
                    end
                    hdrs_checked++;
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (exp_bytes.size() == 0) begin
                    $display("Unexpected tx payload byte at %0t with nothing pending", $time);
                    stream_errors++;
                end else begin
                    beat_want = exp_bytes.pop_front();
                    if (tx_payload !== beat_want) begin
                        print_mismatch("tx_payload", $sformatf("%h", beat_want),
                                       $sformatf("%h", tx_payload));
                        stream_errors++;
                    end
                    // LED follows one cycle after the frame's final byte at the latest
                    if (beat_want.last && exp_led.size() != 0) begin
                        led_want      = exp_led.pop_front();
                        led_check_due = 1'b1;
                    end
                    bytes_checked++;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
        print_summary();
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rx_hdr_valid     = 1'b0;
        rx_hdr           = '0;
        rx_payload_valid = 1'b0;
        rx_payload       = '0;
        hdr_ready_mode   = READY_ON;
        pay_ready_mode   = READY_ON;
        test_reset();
        test_echo();
        test_discard();
        test_backpressure();
        print_summary();
        if (check_errors + stream_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_echo.f
logic/udp_echo_pkg.sv
logic/echo_ctrl.sv
logic/reply_header_build.sv
logic/payload_fifo.sv
logic/led_capture.sv
logic/udp_echo_top.sv
tests/tb_clock_gen.sv
tests/tb_udp_echo.sv
